//--- verilog/bpu_pkg.sv
// Shared branch kinds, width types and default sizes for the predictor update path
package bpu_pkg;

    // word address, bit 0 is the slot in a two-instruction fetch packet
    typedef logic [29:0] pc_t;

    // chooser value from predecode, carried through untouched
    typedef logic [1:0] choice_t;

    // 2-bit saturating counter
    typedef logic [1:0] ctr_t;

    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        CALL          = 3'd2,
        RET           = 3'd3,
        INDIRECT_JUMP = 3'd4,
        OTHER_JUMP    = 3'd5
    } br_kind_e;

    localparam ctr_t CTR_WEAK_NT = 2'd1;

    // defaults, overridden from the top level
    localparam int BUF_DEPTH_DEF  = 4;
    localparam int BANK_BITS_DEF  = 2;
    localparam int INDEX_BITS_DEF = 4;

endpackage

//--- verilog/ex_update_buffer.sv
// Queues execute branch records, merges aligned packet pairs and registers one update per pop
`timescale 1ns/1ps

module ex_update_buffer
    import bpu_pkg::*;
#(
    parameter int BUF_DEPTH = BUF_DEPTH_DEF
) (
    input  logic      clk,
    input  logic      rstn,
    // 1 pushes lane 0 alone, 0 pushes both lanes
    input  logic      flag,
    input  logic      stall,

    input  logic      ex_taken_pdc_0,
    input  br_kind_e  ex_kind_pdc_0,
    input  pc_t       ex_npc_pdc_0,
    input  choice_t   ex_choice_pdc_0,
    input  logic      ex_taken_ex_0,
    input  br_kind_e  ex_kind_ex_0,
    input  pc_t       ex_npc_ex_0,
    input  pc_t       ex_pc_ex_0,

    input  logic      ex_taken_pdc_1,
    input  br_kind_e  ex_kind_pdc_1,
    input  pc_t       ex_npc_pdc_1,
    input  choice_t   ex_choice_pdc_1,
    input  logic      ex_taken_ex_1,
    input  br_kind_e  ex_kind_ex_1,
    input  pc_t       ex_npc_ex_1,
    input  pc_t       ex_pc_ex_1,

    output logic      upd_valid,
    output logic      upd_taken_pdc,
    output br_kind_e  upd_kind_pdc,
    output pc_t       upd_npc_pdc,
    output choice_t   upd_choice_pdc,
    output logic      upd_taken_ex,
    output br_kind_e  upd_kind_ex,
    output pc_t       upd_npc_ex,
    output pc_t       upd_pc_ex
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    // record storage, one array per field
    logic      taken_pdc_q  [BUF_DEPTH];
    br_kind_e  kind_pdc_q   [BUF_DEPTH];
    pc_t       npc_pdc_q    [BUF_DEPTH];
    choice_t   choice_pdc_q [BUF_DEPTH];
    logic      taken_ex_q   [BUF_DEPTH];
    br_kind_e  kind_ex_q    [BUF_DEPTH];
    pc_t       npc_ex_q     [BUF_DEPTH];
    pc_t       pc_ex_q      [BUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_1;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] head_1;
    logic [CNT_W-1:0] count;
    logic [1:0]       push_n;
    logic [1:0]       pop_n;

    logic      m_taken_ex;
    br_kind_e  m_kind_ex;
    pc_t       m_npc_ex;

    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                                 input logic [1:0] n);
        logic [PTR_W:0] sum;
        sum = (PTR_W+1)'(ptr) + (PTR_W+1)'(n);
        if (sum >= (PTR_W+1)'(BUF_DEPTH))
            sum = sum - (PTR_W+1)'(BUF_DEPTH);
        return sum[PTR_W-1:0];
    endfunction

    // first kind in priority order found in either record
    function automatic br_kind_e merge_kind(input br_kind_e k0, input br_kind_e k1);
        br_kind_e k;
        if (k0 == DIRECT_JUMP || k1 == DIRECT_JUMP)
            k = DIRECT_JUMP;
        else if (k0 == CALL || k1 == CALL)
            k = CALL;
        else if (k0 == RET || k1 == RET)
            k = RET;
        else if (k0 == INDIRECT_JUMP || k1 == INDIRECT_JUMP)
            k = INDIRECT_JUMP;
        else if (k0 == OTHER_JUMP || k1 == OTHER_JUMP)
            k = OTHER_JUMP;
        else
            k = NOT_JUMP;
        return k;
    endfunction

    assign push_n   = stall ? 2'd0 : (flag ? 2'd1 : 2'd2);
    assign head     = rd_ptr;
    assign head_1   = ptr_add(rd_ptr, 2'd1);
    assign wr_ptr_1 = ptr_add(wr_ptr, 2'd1);

    // pop decision from the head record
    always_comb begin
        pop_n = 2'd0;
        if (count != '0 && pc_ex_q[head][0])
            pop_n = 2'd1;
        else if (count >= CNT_W'(2) && !pc_ex_q[head][0])
            pop_n = 2'd2;
    end

    always_comb begin
        m_taken_ex = taken_ex_q[head];
        m_kind_ex  = kind_ex_q[head];
        m_npc_ex   = npc_ex_q[head];
        if (pop_n == 2'd2) begin
            m_taken_ex = taken_ex_q[head] | taken_ex_q[head_1];
            m_kind_ex  = merge_kind(kind_ex_q[head], kind_ex_q[head_1]);
            m_npc_ex   = taken_ex_q[head] ? npc_ex_q[head] : npc_ex_q[head_1];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= ptr_add(rd_ptr, pop_n);
            wr_ptr <= ptr_add(wr_ptr, push_n);
            count  <= count - CNT_W'(pop_n) + CNT_W'(push_n);
        end
    end

    always_ff @(posedge clk) begin
        if (push_n != 2'd0) begin
            taken_pdc_q[wr_ptr]  <= ex_taken_pdc_0;
            kind_pdc_q[wr_ptr]   <= ex_kind_pdc_0;
            npc_pdc_q[wr_ptr]    <= ex_npc_pdc_0;
            choice_pdc_q[wr_ptr] <= ex_choice_pdc_0;
            taken_ex_q[wr_ptr]   <= ex_taken_ex_0;
            kind_ex_q[wr_ptr]    <= ex_kind_ex_0;
            npc_ex_q[wr_ptr]     <= ex_npc_ex_0;
            pc_ex_q[wr_ptr]      <= ex_pc_ex_0;
        end
        // lane 1 goes in behind lane 0
        if (push_n == 2'd2) begin
            taken_pdc_q[wr_ptr_1]  <= ex_taken_pdc_1;
            kind_pdc_q[wr_ptr_1]   <= ex_kind_pdc_1;
            npc_pdc_q[wr_ptr_1]    <= ex_npc_pdc_1;
            choice_pdc_q[wr_ptr_1] <= ex_choice_pdc_1;
            taken_ex_q[wr_ptr_1]   <= ex_taken_ex_1;
            kind_ex_q[wr_ptr_1]    <= ex_kind_ex_1;
            npc_ex_q[wr_ptr_1]     <= ex_npc_ex_1;
            pc_ex_q[wr_ptr_1]      <= ex_pc_ex_1;
        end
    end

    // registered update, cuts the path into the predictor
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            upd_valid      <= 1'b0;
            upd_taken_pdc  <= 1'b0;
            upd_kind_pdc   <= NOT_JUMP;
            upd_npc_pdc    <= '0;
            upd_choice_pdc <= '0;
            upd_taken_ex   <= 1'b0;
            upd_kind_ex    <= NOT_JUMP;
            upd_npc_ex     <= '0;
            upd_pc_ex      <= '0;
        end else begin
            upd_valid <= (pop_n != 2'd0);
            if (pop_n != 2'd0) begin
                upd_taken_pdc  <= taken_pdc_q[head];
                upd_kind_pdc   <= kind_pdc_q[head];
                upd_npc_pdc    <= npc_pdc_q[head];
                upd_choice_pdc <= choice_pdc_q[head];
                upd_taken_ex   <= m_taken_ex;
                upd_kind_ex    <= m_kind_ex;
                upd_npc_ex     <= m_npc_ex;
                upd_pc_ex      <= pc_ex_q[head];
            end
        end
    end

endmodule

//--- verilog/pht_update_router.sv
// Turns a resolved update into a one-hot bank strobe, an entry index and a train direction
`timescale 1ns/1ps

module pht_update_router
    import bpu_pkg::*;
#(
    parameter int BANK_BITS  = BANK_BITS_DEF,
    parameter int INDEX_BITS = INDEX_BITS_DEF
) (
    input  logic                         upd_valid,
    input  br_kind_e                     upd_kind_ex,
    input  logic                         upd_taken_ex,
    input  pc_t                          upd_pc_ex,
    output logic [(1 << BANK_BITS)-1:0]  bank_we,
    output logic [INDEX_BITS-1:0]        wr_index,
    output logic                         wr_taken
);

    localparam int NUM_BANKS = 1 << BANK_BITS;

    logic                 train;
    logic [BANK_BITS-1:0] bank_sel;

    // plain instructions never train
    assign train = upd_valid && (upd_kind_ex != NOT_JUMP);

    // pc bit 0 is the packet slot, banks start above it
    assign bank_sel = upd_pc_ex[BANK_BITS:1];
    assign wr_index = upd_pc_ex[BANK_BITS+INDEX_BITS:BANK_BITS+1];
    assign wr_taken = upd_taken_ex;

    always_comb begin
        bank_we = '0;
        if (train)
            bank_we = NUM_BANKS'(1) << bank_sel;
    end

endmodule

//--- verilog/pht_bank.sv
// One bank of 2-bit saturating counters with a training write port and a combinational read
`timescale 1ns/1ps

module pht_bank
    import bpu_pkg::*;
#(
    parameter int INDEX_BITS = INDEX_BITS_DEF
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  we,
    input  logic [INDEX_BITS-1:0] wr_index,
    input  logic                  wr_taken,
    input  logic [INDEX_BITS-1:0] rd_index,
    output ctr_t                  rd_ctr
);

    localparam int NUM_ENTRIES = 1 << INDEX_BITS;

    ctr_t ctr_q [NUM_ENTRIES];
    ctr_t cur_ctr;
    ctr_t nxt_ctr;

    assign cur_ctr = ctr_q[wr_index];

    // saturate at both ends
    always_comb begin
        nxt_ctr = cur_ctr;
        if (wr_taken) begin
            if (cur_ctr != 2'd3)
                nxt_ctr = cur_ctr + 2'd1;
        end else begin
            if (cur_ctr != 2'd0)
                nxt_ctr = cur_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_ENTRIES; i++)
                ctr_q[i] <= CTR_WEAK_NT;
        end else if (we) begin
            ctr_q[wr_index] <= nxt_ctr;
        end
    end

    // old value on a same-edge write
    assign rd_ctr = ctr_q[rd_index];

endmodule

//--- verilog/pht_predict_select.sv
// Splits a lookup pc into bank and index, picks that bank's counter and registers the prediction
`timescale 1ns/1ps

module pht_predict_select
    import bpu_pkg::*;
#(
    parameter int BANK_BITS  = BANK_BITS_DEF,
    parameter int INDEX_BITS = INDEX_BITS_DEF
) (
    input  logic                                       clk,
    input  logic                                       rstn,
    input  logic                                       lookup_en,
    input  pc_t                                        lookup_pc,
    input  logic [(1 << BANK_BITS)*$bits(ctr_t)-1:0]   bank_ctr,
    output logic [INDEX_BITS-1:0]                      rd_index,
    output logic                                       predict_valid,
    output logic                                       predict_taken
);

    localparam int CTR_W = $bits(ctr_t);

    logic [BANK_BITS-1:0] bank_sel;
    ctr_t                 sel_ctr;

    // same field split as the update side
    assign bank_sel = lookup_pc[BANK_BITS:1];
    assign rd_index = lookup_pc[BANK_BITS+INDEX_BITS:BANK_BITS+1];
    assign sel_ctr  = bank_ctr[bank_sel*CTR_W +: CTR_W];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            predict_valid <= 1'b0;
            predict_taken <= 1'b0;
        end else begin
            predict_valid <= lookup_en;
            // upper counter bit is the direction
            predict_taken <= lookup_en & sel_ctr[CTR_W-1];
        end
    end

endmodule

//--- verilog/bpu_update_top.sv
// Top of the predictor update path: buffer, router, counter banks and lookup select
`timescale 1ns/1ps

module bpu_update_top
    import bpu_pkg::*;
#(
    parameter int BUF_DEPTH  = BUF_DEPTH_DEF,
    parameter int BANK_BITS  = BANK_BITS_DEF,
    parameter int INDEX_BITS = INDEX_BITS_DEF
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      flag,
    input  logic      stall,

    input  logic      ex_taken_pdc_0,
    input  br_kind_e  ex_kind_pdc_0,
    input  pc_t       ex_npc_pdc_0,
    input  choice_t   ex_choice_pdc_0,
    input  logic      ex_taken_ex_0,
    input  br_kind_e  ex_kind_ex_0,
    input  pc_t       ex_npc_ex_0,
    input  pc_t       ex_pc_ex_0,

    input  logic      ex_taken_pdc_1,
    input  br_kind_e  ex_kind_pdc_1,
    input  pc_t       ex_npc_pdc_1,
    input  choice_t   ex_choice_pdc_1,
    input  logic      ex_taken_ex_1,
    input  br_kind_e  ex_kind_ex_1,
    input  pc_t       ex_npc_ex_1,
    input  pc_t       ex_pc_ex_1,

    input  logic      lookup_en,
    input  pc_t       lookup_pc,

    output logic      upd_valid,
    output logic      upd_taken_pdc,
    output br_kind_e  upd_kind_pdc,
    output pc_t       upd_npc_pdc,
    output choice_t   upd_choice_pdc,
    output logic      upd_taken_ex,
    output br_kind_e  upd_kind_ex,
    output pc_t       upd_npc_ex,
    output pc_t       upd_pc_ex,

    output logic      predict_valid,
    output logic      predict_taken
);

    localparam int NUM_BANKS = 1 << BANK_BITS;
    localparam int CTR_W     = $bits(ctr_t);

    logic [NUM_BANKS-1:0]       bank_we;
    logic [INDEX_BITS-1:0]      wr_index;
    logic                       wr_taken;
    logic [INDEX_BITS-1:0]      rd_index;
    logic [NUM_BANKS*CTR_W-1:0] bank_ctr;

    ex_update_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_buf (
        .clk             (clk),
        .rstn            (rstn),
        .flag            (flag),
        .stall           (stall),
        .ex_taken_pdc_0  (ex_taken_pdc_0),
        .ex_kind_pdc_0   (ex_kind_pdc_0),
        .ex_npc_pdc_0    (ex_npc_pdc_0),
        .ex_choice_pdc_0 (ex_choice_pdc_0),
        .ex_taken_ex_0   (ex_taken_ex_0),
        .ex_kind_ex_0    (ex_kind_ex_0),
        .ex_npc_ex_0     (ex_npc_ex_0),
        .ex_pc_ex_0      (ex_pc_ex_0),
        .ex_taken_pdc_1  (ex_taken_pdc_1),
        .ex_kind_pdc_1   (ex_kind_pdc_1),
        .ex_npc_pdc_1    (ex_npc_pdc_1),
        .ex_choice_pdc_1 (ex_choice_pdc_1),
        .ex_taken_ex_1   (ex_taken_ex_1),
        .ex_kind_ex_1    (ex_kind_ex_1),
        .ex_npc_ex_1     (ex_npc_ex_1),
        .ex_pc_ex_1      (ex_pc_ex_1),
        .upd_valid       (upd_valid),
        .upd_taken_pdc   (upd_taken_pdc),
        .upd_kind_pdc    (upd_kind_pdc),
        .upd_npc_pdc     (upd_npc_pdc),
        .upd_choice_pdc  (upd_choice_pdc),
        .upd_taken_ex    (upd_taken_ex),
        .upd_kind_ex     (upd_kind_ex),
        .upd_npc_ex      (upd_npc_ex),
        .upd_pc_ex       (upd_pc_ex)
    );

    pht_update_router #(
        .BANK_BITS  (BANK_BITS),
        .INDEX_BITS (INDEX_BITS)
    ) u_router (
        .upd_valid    (upd_valid),
        .upd_kind_ex  (upd_kind_ex),
        .upd_taken_ex (upd_taken_ex),
        .upd_pc_ex    (upd_pc_ex),
        .bank_we      (bank_we),
        .wr_index     (wr_index),
        .wr_taken     (wr_taken)
    );

    // index and direction are shared, only the strobe differs per bank
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        pht_bank #(
            .INDEX_BITS (INDEX_BITS)
        ) u_bank (
            .clk      (clk),
            .rstn     (rstn),
            .we       (bank_we[b]),
            .wr_index (wr_index),
            .wr_taken (wr_taken),
            .rd_index (rd_index),
            .rd_ctr   (bank_ctr[b*CTR_W +: CTR_W])
        );
    end

    pht_predict_select #(
        .BANK_BITS  (BANK_BITS),
        .INDEX_BITS (INDEX_BITS)
    ) u_sel (
        .clk           (clk),
        .rstn          (rstn),
        .lookup_en     (lookup_en),
        .lookup_pc     (lookup_pc),
        .bank_ctr      (bank_ctr),
        .rd_index      (rd_index),
        .predict_valid (predict_valid),
        .predict_taken (predict_taken)
    );

endmodule

//--- verification/bpu_update_chk.sv
// Assertions bound into the update buffer on occupancy and the update strobe after reset
`timescale 1ns/1ps

module bpu_update_chk
    import bpu_pkg::*;
#(
    parameter int BUF_DEPTH = BUF_DEPTH_DEF,
    parameter int CNT_W     = 3
) (
    input logic             clk,
    input logic             rstn,
    input logic [CNT_W-1:0] count,
    input logic [1:0]       push_n,
    input logic [1:0]       pop_n,
    input logic             upd_valid
);

    logic assert_fail = 1'b0;
    logic pushed;

    // any record accepted since reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            pushed <= 1'b0;
        else if (push_n != 2'd0)
            pushed <= 1'b1;
    end

    a_count_max: assert property (@(posedge clk) disable iff (!rstn)
        int'(count) <= BUF_DEPTH)
        else begin
            assert_fail = 1'b1;
            $error("buffer count above its depth");
        end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        int'(count) - int'(pop_n) + int'(push_n) <= BUF_DEPTH)
        else begin
            assert_fail = 1'b1;
            $error("push would overflow the buffer");
        end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        !pushed |-> !upd_valid)
        else begin
            assert_fail = 1'b1;
            $error("update strobe before any record was pushed");
        end

endmodule

bind ex_update_buffer bpu_update_chk #(
    .BUF_DEPTH (BUF_DEPTH),
    .CNT_W     (CNT_W)
) u_chk (
    .clk       (clk),
    .rstn      (rstn),
    .count     (count),
    .push_n    (push_n),
    .pop_n     (pop_n),
    .upd_valid (upd_valid)
);

//--- verification/tb_bpu_update.sv
// Testbench for the predictor update path, replays the trace file and checks updates and lookups
`timescale 1ns/1ps

module tb_bpu_update
    import bpu_pkg::*;
();

    localparam int TIMEOUT = 20;

    logic     clk;
    logic     rstn;
    logic     flag;
    logic     stall;
    logic     ex_taken_pdc_0;
    br_kind_e ex_kind_pdc_0;
    pc_t      ex_npc_pdc_0;
    choice_t  ex_choice_pdc_0;
    logic     ex_taken_ex_0;
    br_kind_e ex_kind_ex_0;
    pc_t      ex_npc_ex_0;
    pc_t      ex_pc_ex_0;
    logic     ex_taken_pdc_1;
    br_kind_e ex_kind_pdc_1;
    pc_t      ex_npc_pdc_1;
    choice_t  ex_choice_pdc_1;
    logic     ex_taken_ex_1;
    br_kind_e ex_kind_ex_1;
    pc_t      ex_npc_ex_1;
    pc_t      ex_pc_ex_1;
    logic     lookup_en;
    pc_t      lookup_pc;
    logic     upd_valid;
    logic     upd_taken_pdc;
    br_kind_e upd_kind_pdc;
    pc_t      upd_npc_pdc;
    choice_t  upd_choice_pdc;
    logic     upd_taken_ex;
    br_kind_e upd_kind_ex;
    pc_t      upd_npc_ex;
    pc_t      upd_pc_ex;
    logic     predict_valid;
    logic     predict_taken;

    // expected update fields, eight entries per update in trace order
    logic [31:0] exp_q [$];

    bpu_update_top u_dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    // flag, stall, then eight fields per lane
    task automatic set_lanes(input logic [31:0] f [18]);
        flag            = f[0][0];
        stall           = f[1][0];
        ex_taken_pdc_0  = f[2][0];
        ex_kind_pdc_0   = br_kind_e'(f[3][2:0]);
        ex_npc_pdc_0    = f[4][29:0];
        ex_choice_pdc_0 = f[5][1:0];
        ex_taken_ex_0   = f[6][0];
        ex_kind_ex_0    = br_kind_e'(f[7][2:0]);
        ex_npc_ex_0     = f[8][29:0];
        ex_pc_ex_0      = f[9][29:0];
        ex_taken_pdc_1  = f[10][0];
        ex_kind_pdc_1   = br_kind_e'(f[11][2:0]);
        ex_npc_pdc_1    = f[12][29:0];
        ex_choice_pdc_1 = f[13][1:0];
        ex_taken_ex_1   = f[14][0];
        ex_kind_ex_1    = br_kind_e'(f[15][2:0]);
        ex_npc_ex_1     = f[16][29:0];
        ex_pc_ex_1      = f[17][29:0];
    endtask

    // returns 1 ns after an edge once every expected update was seen
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT)
                abort_run("timed out waiting for an expected update");
        end
    endtask

    task automatic lookup_check(input pc_t pc, input logic exp_taken);
        int cycles;
        // counters must hold all earlier updates first
        wait_drained();
        lookup_en = 1'b1;
        lookup_pc = pc;
        @(posedge clk);
        #1;
        lookup_en = 1'b0;
        cycles = 0;
        while (!predict_valid) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT)
                abort_run("timed out waiting for predict_valid");
        end
        check_value("predict_taken", 32'(predict_taken), 32'(exp_taken));
    endtask

    // every update must match the next expected one
    always @(negedge clk) begin
        if (u_dut.u_buf.u_chk.assert_fail) begin
            abort_run("an assertion on the update buffer failed");
        end else if (rstn && upd_valid) begin
            if (exp_q.size() < 8) begin
                abort_run("update seen while the trace expects none");
            end else begin
                check_value("upd_taken_pdc", 32'(upd_taken_pdc), exp_q.pop_front());
                check_value("upd_kind_pdc", 32'(upd_kind_pdc), exp_q.pop_front());
                check_value("upd_npc_pdc", 32'(upd_npc_pdc), exp_q.pop_front());
                check_value("upd_choice_pdc", 32'(upd_choice_pdc), exp_q.pop_front());
                check_value("upd_taken_ex", 32'(upd_taken_ex), exp_q.pop_front());
                check_value("upd_kind_ex", 32'(upd_kind_ex), exp_q.pop_front());
                check_value("upd_npc_ex", 32'(upd_npc_ex), exp_q.pop_front());
                check_value("upd_pc_ex", 32'(upd_pc_ex), exp_q.pop_front());
            end
        end
    end

    initial begin
        int          fd;
        string       line;
        byte         cmd;
        logic [31:0] v [18];

        v = '{default: '0};
        set_lanes(v);
        flag      = 1'b1;
        stall     = 1'b1;
        lookup_en = 1'b0;
        lookup_pc = '0;
        rstn      = 1'b0;

        // two edges in reset, then two more with nothing pending
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            if (i == 1)
                rstn = 1'b1;
            check_value("upd_valid", 32'(upd_valid), 32'h0);
            check_value("predict_valid", 32'(predict_valid), 32'h0);
        end

        fd = $fopen("verification/bpu_update_trace.txt", "r");
        if (fd == 0)
            abort_run("could not open the trace file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            cmd = line.getc(0);
            if (cmd == "P") begin
                void'($sscanf(line, "P %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                              v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17]));
                set_lanes(v);
                @(posedge clk);
                #1;
                stall = 1'b1;
            end else if (cmd == "E") begin
                void'($sscanf(line, "E %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]));
                for (int i = 0; i < 8; i++)
                    exp_q.push_back(v[i]);
            end else if (cmd == "L") begin
                void'($sscanf(line, "L %h %h", v[0], v[1]));
                lookup_check(v[0][29:0], v[1][0]);
            end else if (cmd == "I") begin
                void'($sscanf(line, "I %h", v[0]));
                repeat (int'(v[0])) @(posedge clk);
                #1;
            end else begin
                abort_run($sformatf("unknown trace command %s", line));
            end
        end
        $fclose(fd);
        wait_drained();

        if (u_dut.u_buf.u_chk.assert_fail) begin
            abort_run("an assertion on the update buffer failed");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- verification/bpu_update_trace.txt
# P flag stall, lane 0 then lane 1: taken_pdc kind_pdc npc_pdc choice_pdc taken_ex kind_ex npc_ex pc
# E taken_pdc kind_pdc npc_pdc choice_pdc taken_ex kind_ex npc_ex pc / L pc taken / I cycles (hex)
L 40 0
P 1 0 1 1 200 2 1 1 204 11 0 0 0 0 0 0 0 0
P 1 0 0 4 0 1 1 4 300 23 0 0 0 0 0 0 0 0
E 1 1 200 2 1 1 204 11
E 0 4 0 1 1 4 300 23
P 0 0 0 0 61 1 0 3 61 60 1 2 500 3 1 2 500 61
E 0 0 61 1 1 2 500 60
P 0 0 1 4 700 0 1 4 700 70 0 0 0 2 0 1 800 71
E 1 4 700 0 1 1 700 70
P 1 0 0 0 0 0 0 0 0 a0 0 0 0 0 0 0 0 0
P 0 1 1 5 123 3 1 5 456 b1 1 5 123 3 1 5 456 b3
I 2
P 1 0 1 3 900 1 1 3 904 a1 0 0 0 0 0 0 0 0
E 0 0 0 0 1 3 904 a0
P 1 0 1 1 100 0 1 1 100 41 0 0 0 0 0 0 0 0
P 1 0 1 1 100 0 1 1 100 41 0 0 0 0 0 0 0 0
E 1 1 100 0 1 1 100 41
E 1 1 100 0 1 1 100 41
L 40 1
P 1 0 1 1 100 0 1 1 100 41 0 0 0 0 0 0 0 0
E 1 1 100 0 1 1 100 41
L 40 1
P 1 0 0 1 100 0 0 1 100 41 0 0 0 0 0 0 0 0
P 1 0 0 1 100 0 0 1 100 41 0 0 0 0 0 0 0 0
E 0 1 100 0 0 1 100 41
E 0 1 100 0 0 1 100 41
P 1 0 0 1 100 0 0 1 100 41 0 0 0 0 0 0 0 0
E 0 1 100 0 0 1 100 41
L 40 0
P 1 0 0 1 100 0 0 1 100 41 0 0 0 0 0 0 0 0
E 0 1 100 0 0 1 100 41
L 40 0
P 1 0 1 0 100 0 1 0 100 41 0 0 0 0 0 0 0 0
P 1 0 1 0 100 0 1 0 100 41 0 0 0 0 0 0 0 0
E 1 0 100 0 1 0 100 41
E 1 0 100 0 1 0 100 41
L 40 0
P 1 0 1 1 180 0 1 1 180 43 0 0 0 0 0 0 0 0
P 1 0 1 1 180 0 1 1 180 43 0 0 0 0 0 0 0 0
E 1 1 180 0 1 1 180 43
E 1 1 180 0 1 1 180 43
L 42 1
L 40 0
L 44 0

//--- compile.f
verilog/bpu_pkg.sv
verilog/ex_update_buffer.sv
verilog/pht_update_router.sv
verilog/pht_bank.sv
verilog/pht_predict_select.sv
verilog/bpu_update_top.sv
verification/bpu_update_chk.sv
verification/tb_bpu_update.sv

//--- Makefile
TOP       ?= tb_bpu_update
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
